/* Bender.yml */
package:
  name: decode_stage

sources:
  - rv_isa_pkg.sv
  - decode_pkg.sv
  - operand_forward.sv
  - branch_resolve.sv
  - inst_decoder.sv
  - decode_register.sv
  - decode_stage_top.sv
  - target: test
    files:
      - decode_stage_props.sv
      - tb_decode_stage.sv

/* branch_resolve.sv */
`timescale 1ns/1ns

module branch_resolve import rv_isa_pkg::*; (
    input  logic [2:0] funct3,
    input  word_t      op_a,
    input  word_t      op_b,
    output logic       branch_taken
);

    logic lt_s;
    logic lt_u;

    assign lt_s = $signed(op_a) < $signed(op_b);   // BLT and BGE
    assign lt_u = op_a < op_b;                     // BLTU and BGEU

    always_comb begin
        case (funct3)
            F3_BEQ:  branch_taken = (op_a == op_b);
            F3_BNE:  branch_taken = (op_a != op_b);
            F3_BLT:  branch_taken = lt_s;
            F3_BGE:  branch_taken = !lt_s;
            F3_BLTU: branch_taken = lt_u;
            F3_BGEU: branch_taken = !lt_u;
            default: branch_taken = 1'b0;   // 010 and 011 are reserved
        endcase
    end

endmodule

/* decode_pkg.sv */
package decode_pkg;

    import rv_isa_pkg::*;

    // Zero encodings are the inactive values so a cleared record is a bubble
    typedef enum logic [3:0] {
        ALU_NOP  = 4'd0,
        ALU_ADD  = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_SLL  = 4'd3,
        ALU_SLT  = 4'd4,
        ALU_SLTU = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_SRL  = 4'd7,
        ALU_SRA  = 4'd8,
        ALU_OR   = 4'd9,
        ALU_AND  = 4'd10
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NOP   = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    // Access width and extension, used by memory and writeback
    typedef enum logic [2:0] {
        WB_WORD   = 3'd0,
        WB_HALF_S = 3'd1,
        WB_HALF_U = 3'd2,
        WB_BYTE_S = 3'd3,
        WB_BYTE_U = 3'd4
    } wb_type_e;

    typedef struct packed {
        reg_addr_t rd;                      // Destination of the in-flight result
        word_t     data;
    } fwd_src_t;

    typedef fwd_src_t [NUM_FWD-1:0] fwd_bus_t;   // Index 0 is execute

    typedef struct packed {
        reg_addr_t rd;
        alu_op_e   alu_op;
        mem_op_e   mem_op;
        logic      wb_en;                   // Register write in writeback
        logic      wb_from_alu;             // Write ALU result, else load data
        wb_type_e  wb_type;
        logic      update_pc;               // ALU result is the new PC
    } decode_ctrl_t;

    typedef struct packed {
        decode_ctrl_t ctrl;
        word_t        alu_a;
        word_t        alu_b;
        word_t        store_data;
    } issue_t;

endpackage

/* decode_register.sv */
`timescale 1ns/1ns

module decode_register import decode_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  issue_t issue_next,
    output issue_t issue
);

    // Cleared record is a bubble for execute
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue <= '0;
        end else begin
            issue <= issue_next;            // Lockstep pipeline, loads every cycle
        end
    end

endmodule

/* decode_stage_props.sv */
`timescale 1ns/1ns

module decode_stage_props import decode_pkg::*; (
    input logic   clk,
    input logic   rst_n,
    input issue_t issue
);

    int unsigned error_count = 0;           // Number of failed assertions

    // Async clear lands before the first edge of reset
    reset_clear: assert property (@(posedge clk) !rst_n |-> (issue == '0))
        else begin
            $error("issue record not cleared while reset is asserted");
            error_count++;
        end

    store_no_wb: assert property (@(posedge clk) disable iff (!rst_n)
        (issue.ctrl.mem_op == MEM_STORE) |-> !issue.ctrl.wb_en)
        else begin
            $error("store record has register write enabled");
            error_count++;
        end

    // New PC is always an ALU sum
    pc_needs_add: assert property (@(posedge clk) disable iff (!rst_n)
        issue.ctrl.update_pc |-> (issue.ctrl.alu_op == ALU_ADD))
        else begin
            $error("update_pc set without ALU add");
            error_count++;
        end

endmodule

bind decode_stage_top decode_stage_props decode_stage_props_i (
    .clk   (clk),
    .rst_n (rst_n),
    .issue (issue)
);

/* decode_stage_top.sv */
`timescale 1ns/1ns

module decode_stage_top import rv_isa_pkg::*; import decode_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  inst_t     inst,
    input  word_t     pc,
    input  word_t     rs1_data,             // Register file read data, same cycle
    input  word_t     rs2_data,
    input  fwd_bus_t  fwd,                  // Results from execute, memory, writeback
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output issue_t    issue
);

    word_t  op_a;
    word_t  op_b;
    logic   branch_taken;
    issue_t issue_next;

    operand_forward operand_forward_i (
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .fwd      (fwd),
        .op_a     (op_a),
        .op_b     (op_b)
    );

    branch_resolve branch_resolve_i (
        .funct3       (inst.b.funct3),
        .op_a         (op_a),
        .op_b         (op_b),
        .branch_taken (branch_taken)
    );

    inst_decoder inst_decoder_i (
        .inst         (inst),
        .pc           (pc),
        .op_a         (op_a),
        .op_b         (op_b),
        .branch_taken (branch_taken),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .issue_next   (issue_next)
    );

    decode_register decode_register_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .issue_next (issue_next),
        .issue      (issue)
    );

endmodule

/* filelist.f */
rv_isa_pkg.sv
decode_pkg.sv
operand_forward.sv
branch_resolve.sv
inst_decoder.sv
decode_register.sv
decode_stage_top.sv
decode_stage_props.sv
tb_decode_stage.sv

/* inst_decoder.sv */
`timescale 1ns/1ns

module inst_decoder import rv_isa_pkg::*; import decode_pkg::*; (
    input  inst_t     inst,
    input  word_t     pc,
    input  word_t     op_a,                 // Forwarded rs1 value
    input  word_t     op_b,                 // Forwarded rs2 value
    input  logic      branch_taken,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output issue_t    issue_next
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;                        // Bit 30 selects SUB and SRA
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    // OP-IMM has no SUBI, bit 30 there belongs to the immediate
    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic sub_sra,
                                        input logic reg_op);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: op = (sub_sra && reg_op) ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = sub_sra ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            F3_AND:     op = ALU_AND;
            default:    op = ALU_NOP;
        endcase
        return op;
    endfunction

    assign opcode = inst.r.opcode;          // Same bits in every format
    assign funct3 = inst.r.funct3;
    assign alt    = inst.r.funct7[5];

    assign imm_i = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
    assign imm_s = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
    assign imm_b = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                    inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
    assign imm_u = {inst.u.imm_31_12, 12'd0};
    assign imm_j = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                    inst.j.imm_11, inst.j.imm_10_1, 1'b0};

    // Register file read ports, kept apart from the record so there is no false loop
    always_comb begin
        rs1_addr = '0;
        rs2_addr = '0;
        case (opcode)
            OPC_BRANCH, OPC_STORE, OPC_OP: begin
                rs1_addr = inst.r.rs1;
                rs2_addr = inst.r.rs2;
            end
            OPC_LOAD, OPC_OP_IMM: rs1_addr = inst.i.rs1;
            default: ;                      // U and J formats read nothing
        endcase
    end

    always_comb begin
        issue_next = '0;                    // Bubble unless the opcode says otherwise
        case (opcode)
            OPC_LUI, OPC_AUIPC: begin
                issue_next.ctrl.rd          = inst.u.rd;
                issue_next.ctrl.alu_op      = ALU_ADD;
                issue_next.ctrl.wb_en       = 1'b1;
                issue_next.ctrl.wb_from_alu = 1'b1;
                issue_next.alu_a            = imm_u;
                issue_next.alu_b            = (opcode == OPC_AUIPC) ? pc : '0;
            end
            OPC_JAL: begin
                issue_next.ctrl.rd          = inst.j.rd;
                issue_next.ctrl.alu_op      = ALU_ADD;   // Jump target
                issue_next.ctrl.wb_en       = 1'b1;
                issue_next.ctrl.wb_from_alu = 1'b1;
                issue_next.ctrl.update_pc   = 1'b1;
                issue_next.alu_a            = imm_j;
                issue_next.alu_b            = pc;
            end
            OPC_BRANCH: begin
                issue_next.ctrl.alu_op      = branch_taken ? ALU_ADD : ALU_NOP;
                issue_next.ctrl.wb_from_alu = 1'b1;
                issue_next.ctrl.update_pc   = branch_taken;
                issue_next.alu_a            = pc;
                issue_next.alu_b            = imm_b;
            end
            OPC_LOAD: begin
                issue_next.ctrl.rd          = inst.i.rd;
                issue_next.ctrl.alu_op      = ALU_ADD;   // Effective address
                issue_next.ctrl.mem_op      = MEM_LOAD;
                issue_next.ctrl.wb_en       = 1'b1;
                issue_next.alu_a            = op_a;
                issue_next.alu_b            = imm_i;
                case (funct3)
                    F3_LB:   issue_next.ctrl.wb_type = WB_BYTE_S;
                    F3_LH:   issue_next.ctrl.wb_type = WB_HALF_S;
                    F3_LW:   issue_next.ctrl.wb_type = WB_WORD;
                    F3_LBU:  issue_next.ctrl.wb_type = WB_BYTE_U;
                    F3_LHU:  issue_next.ctrl.wb_type = WB_HALF_U;
                    default: issue_next.ctrl.wb_type = WB_WORD;
                endcase
            end
            OPC_STORE: begin
                issue_next.ctrl.alu_op      = ALU_ADD;
                issue_next.ctrl.mem_op      = MEM_STORE;
                issue_next.alu_a            = op_a;
                issue_next.alu_b            = imm_s;
                issue_next.store_data       = op_b;      // Forwarded rs2
                case (funct3)               // Only the access width matters here
                    F3_SB:   issue_next.ctrl.wb_type = WB_BYTE_S;
                    F3_SH:   issue_next.ctrl.wb_type = WB_HALF_S;
                    F3_SW:   issue_next.ctrl.wb_type = WB_WORD;
                    default: issue_next.ctrl.wb_type = WB_WORD;
                endcase
            end
            OPC_OP_IMM, OPC_OP: begin
                issue_next.ctrl.rd          = inst.r.rd;
                issue_next.ctrl.alu_op      = alu_sel(funct3, alt, opcode == OPC_OP);
                issue_next.ctrl.wb_en       = 1'b1;
                issue_next.ctrl.wb_from_alu = 1'b1;
                issue_next.alu_a            = op_a;
                issue_next.alu_b            = (opcode == OPC_OP) ? op_b : imm_i;
            end
            OPC_BUBBLE: ;                   // Stall slot
            default: ;                      // Unsupported opcodes also issue nothing
        endcase
    end

endmodule

/* operand_forward.sv */
`timescale 1ns/1ns

module operand_forward import rv_isa_pkg::*; import decode_pkg::*; (
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    input  fwd_bus_t  fwd,
    output word_t     op_a,
    output word_t     op_b
);

    // Walk from the oldest stage to the newest so the nearest match wins
    function automatic word_t pick_operand(
        input reg_addr_t rs,
        input word_t     rf_data,
        input fwd_bus_t  bus
    );
        word_t sel;
        sel = rf_data;                      // Register file unless something newer is in flight
        for (int i = NUM_FWD - 1; i >= 0; i--) begin
            if ((rs != '0) && (bus[i].rd == rs)) begin   // x0 is hardwired, never forwarded
                sel = bus[i].data;
            end
        end
        return sel;
    endfunction

    assign op_a = pick_operand(rs1_addr, rs1_data, fwd);
    assign op_b = pick_operand(rs2_addr, rs2_data, fwd);

endmodule

/* rv_isa_pkg.sv */
package rv_isa_pkg;

    localparam int XLEN       = 32;         // Data path width
    localparam int REG_ADDR_W = 5;          // 32 architectural registers
    localparam int NUM_FWD    = 3;          // Execute, memory and writeback results in flight

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Major opcodes, bits [6:0]
    localparam logic [6:0] OPC_LUI    = 7'b011_0111;
    localparam logic [6:0] OPC_AUIPC  = 7'b001_0111;
    localparam logic [6:0] OPC_JAL    = 7'b110_1111;
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
    localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
    localparam logic [6:0] OPC_STORE  = 7'b010_0011;
    localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
    localparam logic [6:0] OPC_OP     = 7'b011_0011;
    localparam logic [6:0] OPC_BUBBLE = 7'b000_0000;   // Injected by the stall logic upstream

    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;
    localparam logic [2:0] F3_BGE     = 3'b101;
    localparam logic [2:0] F3_BLTU    = 3'b110;
    localparam logic [2:0] F3_BGEU    = 3'b111;

    localparam logic [2:0] F3_LB      = 3'b000;
    localparam logic [2:0] F3_LH      = 3'b001;
    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_LBU     = 3'b100;
    localparam logic [2:0] F3_LHU     = 3'b101;

    localparam logic [2:0] F3_SB      = 3'b000;
    localparam logic [2:0] F3_SH      = 3'b001;
    localparam logic [2:0] F3_SW      = 3'b010;

    // Shared by OP and OP-IMM, bit 30 picks SUB and SRA
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;                 // Sign bit
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic        imm_20;                // Sign bit
        logic [9:0]  imm_10_1;
        logic        imm_11;
        logic [7:0]  imm_19_12;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } j_fmt_t;

    // One fetched word, viewed as the format its opcode selects
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_t;

endpackage

/* tb_decode_stage.sv */
`timescale 1ns/1ns

module tb_decode_stage import rv_isa_pkg::*; import decode_pkg::*; ();

    logic      clk;
    logic      rst_n;
    inst_t     inst;
    word_t     pc;
    word_t     rs1_data;
    word_t     rs2_data;
    fwd_bus_t  fwd;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    issue_t    issue;

    typedef struct {
        string     name;
        word_t     inst;
        word_t     pc;
        word_t     rs1_data;
        word_t     rs2_data;
        fwd_bus_t  fwd;
        reg_addr_t rs1_addr;                // Expected in the same cycle
        reg_addr_t rs2_addr;
        issue_t    issue;                   // Expected one cycle later
    } entry_t;

    entry_t      tests[$];
    logic [31:0] lfsr;

    decode_stage_top decode_stage_top_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .inst     (inst),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .fwd      (fwd),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .issue    (issue)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #4 clk = ~clk;              // 8 ns period
    end

    initial begin : reset_gen
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;                    // Released just after the second edge
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic word_t rand_word();
        word_t w;
        w = '0;
        for (int k = 0; k < XLEN; k++) begin
            w = {w[XLEN-2:0], lfsr_step()};   // One step per bit
        end
        return w;
    endfunction

    // Instruction encoders per RV32I format
    function automatic word_t r_word(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t i_word(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                     reg_addr_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_word(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t b_word(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t u_word(logic [19:0] imm, reg_addr_t rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t j_word(logic [20:0] imm, reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic issue_t make_issue(reg_addr_t rd, alu_op_e op, mem_op_e mem,
                                          logic wb_en, logic wb_alu, wb_type_e wbt,
                                          logic upd, word_t a, word_t b, word_t sd);
        issue_t r;
        r.ctrl       = '{rd, op, mem, wb_en, wb_alu, wbt, upd};
        r.alu_a      = a;
        r.alu_b      = b;
        r.store_data = sd;
        return r;
    endfunction

    // Register writing ALU result without memory access
    function automatic issue_t alu_issue(reg_addr_t rd, alu_op_e op, word_t a, word_t b);
        return make_issue(rd, op, MEM_NOP, 1'b1, 1'b1, WB_WORD, 1'b0, a, b, '0);
    endfunction

    function automatic fwd_bus_t fwd_of(reg_addr_t rd0, word_t d0, reg_addr_t rd1, word_t d1,
                                        reg_addr_t rd2, word_t d2);
        fwd_bus_t f;
        f[0] = '{rd0, d0};                  // Execute is the nearest
        f[1] = '{rd1, d1};
        f[2] = '{rd2, d2};                  // Writeback is the farthest
        return f;
    endfunction

    // All stages target x0 so nothing may be forwarded
    function automatic fwd_bus_t idle_fwd();
        return fwd_of(5'd0, rand_word(), 5'd0, rand_word(), 5'd0, rand_word());
    endfunction

    task automatic add_entry(string name, word_t iw, word_t pcv, word_t r1, word_t r2,
                             fwd_bus_t f, reg_addr_t a1, reg_addr_t a2, issue_t exp);
        entry_t e;
        e.name     = name;
        e.inst     = iw;
        e.pc       = pcv;
        e.rs1_data = r1;
        e.rs2_data = r2;
        e.fwd      = f;
        e.rs1_addr = a1;
        e.rs2_addr = a2;
        e.issue    = exp;
        tests.push_back(e);
    endtask

    task automatic build_table();
        add_entry("bubble", '0, 32'h100, rand_word(), rand_word(), idle_fwd(), 5'd0, 5'd0, '0);
        add_entry("add", r_word(7'h00, 5'd2, 5'd1, F3_ADD_SUB, 5'd3), 32'h104, 32'h10, 32'h20,
                  idle_fwd(), 5'd1, 5'd2, alu_issue(5'd3, ALU_ADD, 32'h10, 32'h20));
        add_entry("sub", r_word(7'h20, 5'd6, 5'd5, F3_ADD_SUB, 5'd4), 32'h108, 32'h50, 32'h8,
                  idle_fwd(), 5'd5, 5'd6, alu_issue(5'd4, ALU_SUB, 32'h50, 32'h8));
        add_entry("sra", r_word(7'h20, 5'd8, 5'd7, F3_SRL_SRA, 5'd9), 32'h10c, 32'h8000_0000,
                  32'h4, idle_fwd(), 5'd7, 5'd8, alu_issue(5'd9, ALU_SRA, 32'h8000_0000, 32'h4));
        add_entry("sltu", r_word(7'h00, 5'd11, 5'd10, F3_SLTU, 5'd12), 32'h110, 32'h3, 32'h7,
                  idle_fwd(), 5'd10, 5'd11, alu_issue(5'd12, ALU_SLTU, 32'h3, 32'h7));
        // Bit 30 set inside the immediate still gives ADD for OP-IMM
        add_entry("addi_neg", i_word(12'hff0, 5'd7, F3_ADD_SUB, 5'd8, OPC_OP_IMM), 32'h114,
                  32'h1000, rand_word(), idle_fwd(), 5'd7, 5'd0,
                  alu_issue(5'd8, ALU_ADD, 32'h1000, 32'hffff_fff0));
        add_entry("srai", i_word(12'h403, 5'd9, F3_SRL_SRA, 5'd10, OPC_OP_IMM), 32'h118,
                  32'hf000_0000, rand_word(), idle_fwd(), 5'd9, 5'd0,
                  alu_issue(5'd10, ALU_SRA, 32'hf000_0000, 32'h403));
        add_entry("xori", i_word(12'h800, 5'd13, F3_XOR, 5'd14, OPC_OP_IMM), 32'h11c, 32'h1234,
                  rand_word(), idle_fwd(), 5'd13, 5'd0,
                  alu_issue(5'd14, ALU_XOR, 32'h1234, 32'hffff_f800));
        add_entry("lui", u_word(20'h8_0001, 5'd11, OPC_LUI), 32'h200, rand_word(), rand_word(),
                  idle_fwd(), 5'd0, 5'd0, alu_issue(5'd11, ALU_ADD, 32'h8000_1000, '0));
        add_entry("auipc", u_word(20'h1_2345, 5'd12, OPC_AUIPC), 32'h2000, rand_word(),
                  rand_word(), idle_fwd(), 5'd0, 5'd0,
                  alu_issue(5'd12, ALU_ADD, 32'h1234_5000, 32'h2000));
        // rs1 in stages 0 and 2 where the nearest wins
        add_entry("fwd_nearest", r_word(7'h00, 5'd14, 5'd13, F3_ADD_SUB, 5'd15), 32'h300,
                  rand_word(), 32'h44,
                  fwd_of(5'd13, 32'h0a0a_0a0a, 5'd20, rand_word(), 5'd13, rand_word()),
                  5'd13, 5'd14, alu_issue(5'd15, ALU_ADD, 32'h0a0a_0a0a, 32'h44));
        add_entry("fwd_farthest", r_word(7'h00, 5'd17, 5'd16, F3_OR, 5'd18), 32'h304, 32'h16,
                  rand_word(),
                  fwd_of(5'd19, rand_word(), 5'd20, rand_word(), 5'd17, 32'h5555_7777),
                  5'd16, 5'd17, alu_issue(5'd18, ALU_OR, 32'h16, 32'h5555_7777));
        add_entry("x0_source", r_word(7'h00, 5'd0, 5'd0, F3_AND, 5'd21), 32'h308, 32'h1, 32'h2,
                  idle_fwd(), 5'd0, 5'd0, alu_issue(5'd21, ALU_AND, 32'h1, 32'h2));
        add_entry("lb", i_word(12'h004, 5'd1, F3_LB, 5'd2, OPC_LOAD), 32'h400, 32'h8000,
                  rand_word(), idle_fwd(), 5'd1, 5'd0, make_issue(5'd2, ALU_ADD, MEM_LOAD,
                  1'b1, 1'b0, WB_BYTE_S, 1'b0, 32'h8000, 32'h4, '0));
        add_entry("lh", i_word(12'hffe, 5'd3, F3_LH, 5'd4, OPC_LOAD), 32'h404, 32'h8010,
                  rand_word(), idle_fwd(), 5'd3, 5'd0, make_issue(5'd4, ALU_ADD, MEM_LOAD,
                  1'b1, 1'b0, WB_HALF_S, 1'b0, 32'h8010, 32'hffff_fffe, '0));
        add_entry("lw", i_word(12'h100, 5'd5, F3_LW, 5'd6, OPC_LOAD), 32'h408, 32'h8020,
                  rand_word(), idle_fwd(), 5'd5, 5'd0, make_issue(5'd6, ALU_ADD, MEM_LOAD,
                  1'b1, 1'b0, WB_WORD, 1'b0, 32'h8020, 32'h100, '0));
        add_entry("lbu", i_word(12'h001, 5'd7, F3_LBU, 5'd8, OPC_LOAD), 32'h40c, 32'h8030,
                  rand_word(), idle_fwd(), 5'd7, 5'd0, make_issue(5'd8, ALU_ADD, MEM_LOAD,
                  1'b1, 1'b0, WB_BYTE_U, 1'b0, 32'h8030, 32'h1, '0));
        add_entry("lhu_fwd", i_word(12'h002, 5'd9, F3_LHU, 5'd10, OPC_LOAD), 32'h410,
                  rand_word(), rand_word(),
                  fwd_of(5'd0, rand_word(), 5'd9, 32'hdead_0000, 5'd0, rand_word()),
                  5'd9, 5'd0, make_issue(5'd10, ALU_ADD, MEM_LOAD, 1'b1, 1'b0, WB_HALF_U,
                  1'b0, 32'hdead_0000, 32'h2, '0));
        // Store data always comes through the forwarding path
        add_entry("sb", s_word(12'h010, 5'd3, 5'd4, F3_SB), 32'h500, 32'h9000, rand_word(),
                  fwd_of(5'd3, 32'hab, 5'd0, rand_word(), 5'd0, rand_word()), 5'd4, 5'd3,
                  make_issue(5'd0, ALU_ADD, MEM_STORE, 1'b0, 1'b0, WB_BYTE_S, 1'b0,
                  32'h9000, 32'h10, 32'hab));
        add_entry("sh", s_word(12'hffc, 5'd5, 5'd6, F3_SH), 32'h504, 32'h9100, rand_word(),
                  fwd_of(5'd0, rand_word(), 5'd5, 32'hbeef, 5'd0, rand_word()), 5'd6, 5'd5,
                  make_issue(5'd0, ALU_ADD, MEM_STORE, 1'b0, 1'b0, WB_HALF_S, 1'b0,
                  32'h9100, 32'hffff_fffc, 32'hbeef));
        add_entry("sw", s_word(12'h7ff, 5'd7, 5'd8, F3_SW), 32'h508, 32'h9200, rand_word(),
                  fwd_of(5'd0, rand_word(), 5'd0, rand_word(), 5'd7, 32'hcafe_f00d), 5'd8, 5'd7,
                  make_issue(5'd0, ALU_ADD, MEM_STORE, 1'b0, 1'b0, WB_WORD, 1'b0,
                  32'h9200, 32'h7ff, 32'hcafe_f00d));
        add_entry("beq_taken", b_word(13'h0812, 5'd2, 5'd1, F3_BEQ), 32'h600, 32'h55, 32'h55,
                  idle_fwd(), 5'd1, 5'd2, make_issue(5'd0, ALU_ADD, MEM_NOP, 1'b0, 1'b1,
                  WB_WORD, 1'b1, 32'h600, 32'h812, '0));
        add_entry("bne_not_taken", b_word(13'h0812, 5'd2, 5'd1, F3_BNE), 32'h604, 32'h55, 32'h55,
                  idle_fwd(), 5'd1, 5'd2, make_issue(5'd0, ALU_NOP, MEM_NOP, 1'b0, 1'b1,
                  WB_WORD, 1'b0, 32'h604, 32'h812, '0));
        add_entry("bne_fwd_taken", b_word(13'h0020, 5'd2, 5'd1, F3_BNE), 32'h608, 32'h55, 32'h55,
                  fwd_of(5'd1, 32'h56, 5'd0, rand_word(), 5'd0, rand_word()), 5'd1, 5'd2,
                  make_issue(5'd0, ALU_ADD, MEM_NOP, 1'b0, 1'b1, WB_WORD, 1'b1,
                  32'h608, 32'h20, '0));
        // -16 against 16 where signed and unsigned disagree
        add_entry("blt_neg_pos", b_word(13'h1ff0, 5'd4, 5'd3, F3_BLT), 32'h800, 32'hffff_fff0,
                  32'h10, idle_fwd(), 5'd3, 5'd4, make_issue(5'd0, ALU_ADD, MEM_NOP, 1'b0,
                  1'b1, WB_WORD, 1'b1, 32'h800, 32'hffff_fff0, '0));
        add_entry("bltu_neg_pos", b_word(13'h1ff0, 5'd4, 5'd3, F3_BLTU), 32'h804, 32'hffff_fff0,
                  32'h10, idle_fwd(), 5'd3, 5'd4, make_issue(5'd0, ALU_NOP, MEM_NOP, 1'b0,
                  1'b1, WB_WORD, 1'b0, 32'h804, 32'hffff_fff0, '0));
        add_entry("bgeu_neg_pos", b_word(13'h1ff0, 5'd4, 5'd3, F3_BGEU), 32'h808, 32'hffff_fff0,
                  32'h10, idle_fwd(), 5'd3, 5'd4, make_issue(5'd0, ALU_ADD, MEM_NOP, 1'b0,
                  1'b1, WB_WORD, 1'b1, 32'h808, 32'hffff_fff0, '0));
        add_entry("jal_fwd", j_word(21'h0_a806, 5'd1), 32'h1000, rand_word(), rand_word(),
                  idle_fwd(), 5'd0, 5'd0, make_issue(5'd1, ALU_ADD, MEM_NOP, 1'b1, 1'b1,
                  WB_WORD, 1'b1, 32'h0000_a806, 32'h1000, '0));
        add_entry("jal_back", j_word(21'h1f_fffc, 5'd5), 32'h1100, rand_word(), rand_word(),
                  idle_fwd(), 5'd0, 5'd0, make_issue(5'd5, ALU_ADD, MEM_NOP, 1'b1, 1'b1,
                  WB_WORD, 1'b1, 32'hffff_fffc, 32'h1100, '0));
        add_entry("unknown_opc", 32'hffff_ffff, 32'h1200, rand_word(), rand_word(), idle_fwd(),
                  5'd0, 5'd0, '0);
        add_entry("bubble_end", '0, 32'h1204, rand_word(), rand_word(), idle_fwd(),
                  5'd0, 5'd0, '0);
    endtask

    task automatic apply(entry_t e);
        inst     = e.inst;
        pc       = e.pc;
        rs1_data = e.rs1_data;
        rs2_data = e.rs2_data;
        fwd      = e.fwd;
    endtask

    task automatic check_issue(string name, issue_t exp, issue_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s issue expected %h actual %h", name, exp, act);
            $display("Result: FAILED");
            $fatal(1, "issue record mismatch");
        end
    endtask

    task automatic check_addr(string name, reg_addr_t exp, reg_addr_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
            $display("Result: FAILED");
            $fatal(1, "register address mismatch");
        end
    endtask

    // Bound property failures up to the latest edge
    task automatic poll_assertions(string name);
        if (decode_stage_top_i.decode_stage_props_i.error_count != 0) begin
            $display("ERROR: a bound assertion on the DUT outputs failed before %s", name);
            $display("Result: FAILED");
            $fatal(1, "assertion failure");
        end
    endtask

    initial begin : main
        int cycles;
        inst     = u_word(20'h1_2345, 5'd1, OPC_LUI);   // Live record only the reset can clear
        pc       = '0;
        rs1_data = '0;
        rs2_data = '0;
        fwd      = '0;
        lfsr     = 32'h792f_fbc9;
        build_table();
        @(posedge clk);
        #1;
        check_issue("in_reset", '0, issue);
        check_addr("in_reset rs1_addr", '0, rs1_addr);
        check_addr("in_reset rs2_addr", '0, rs2_addr);
        cycles = 0;
        while (rst_n !== 1'b1) begin        // Wait for reset release
            @(posedge clk);
            cycles++;
            if (cycles > 16) begin
                $display("ERROR: reset never completed after %0d cycles", cycles);
                $display("Result: FAILED");
                $fatal(1, "reset timeout");
            end
        end
        for (int i = 0; i <= tests.size(); i++) begin
            @(posedge clk);
            #1;
            poll_assertions((i < tests.size()) ? tests[i].name : "end of table");
            if (i > 0) begin
                check_issue(tests[i-1].name, tests[i-1].issue, issue);   // Registered last edge
            end
            if (i < tests.size()) begin
                apply(tests[i]);
                #2;
                check_addr({tests[i].name, " rs1_addr"}, tests[i].rs1_addr, rs1_addr);
                check_addr({tests[i].name, " rs2_addr"}, tests[i].rs2_addr, rs2_addr);
            end
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule
